//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam logic [xlen-1:0] reset_pc = '0;

  // base opcodes of the kept rv32i subset
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  localparam int alu_op_w = 4;

  localparam logic [alu_op_w-1:0] alu_add  = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub  = 4'd1;
  localparam logic [alu_op_w-1:0] alu_sll  = 4'd2;
  localparam logic [alu_op_w-1:0] alu_slt  = 4'd3;
  localparam logic [alu_op_w-1:0] alu_sltu = 4'd4;
  localparam logic [alu_op_w-1:0] alu_xor  = 4'd5;
  localparam logic [alu_op_w-1:0] alu_srl  = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sra  = 4'd7;
  localparam logic [alu_op_w-1:0] alu_or   = 4'd8;
  localparam logic [alu_op_w-1:0] alu_and  = 4'd9;

  localparam logic [2:0] cls_invalid = 3'd0;
  localparam logic [2:0] cls_lui     = 3'd1;
  localparam logic [2:0] cls_auipc   = 3'd2;
  localparam logic [2:0] cls_jump    = 3'd3;
  localparam logic [2:0] cls_branch  = 3'd4;
  localparam logic [2:0] cls_load    = 3'd5;
  localparam logic [2:0] cls_store   = 3'd6;
  localparam logic [2:0] cls_alu     = 3'd7;

  localparam logic [2:0] st_fetch      = 3'd0;
  localparam logic [2:0] st_wait_fetch = 3'd1;
  localparam logic [2:0] st_execute    = 3'd2;
  localparam logic [2:0] st_wait_load  = 3'd3;
  localparam logic [2:0] st_wait_store = 3'd4;
  localparam logic [2:0] st_check_pc   = 3'd5;
  localparam logic [2:0] st_reg_write  = 3'd6;
  localparam logic [2:0] st_trap       = 3'd7;

  // one instruction word, seen through each encoding format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } instr_t;

endpackage

`default_nettype wire

//--- rtl/rv_decode.sv
`default_nettype none
`timescale 1ns/10ps

module rv_decode (
  input  rv_pkg::instr_t                instr,
  output logic [rv_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::reg_addr_w-1:0] rd,
  output logic [rv_pkg::xlen-1:0]       imm,
  output logic [2:0]                    instr_class,
  output logic [rv_pkg::alu_op_w-1:0]   alu_op,
  output logic                          use_imm,
  output logic [2:0]                    funct3
);
  import rv_pkg::*;

  logic [6:0]          opcode;
  logic [2:0]          f3;
  logic [6:0]          f7;
  logic                is_jal;
  logic [alu_op_w-1:0] f3_op;

  assign opcode = instr.r.opcode;
  assign f3 = instr.r.funct3;
  assign f7 = instr.r.funct7;
  assign is_jal = opcode == op_jal;

  // jal reads x0 on both ports so that its beq compare is always true
  assign rs1 = is_jal ? '0 : instr.r.rs1;
  assign rs2 = is_jal ? '0 : instr.r.rs2;
  assign rd = (instr_class == cls_branch || instr_class == cls_store) ? '0 : instr.r.rd;

  // shared by op and op-imm, funct7 variants patched below
  always_comb begin
    case (f3)
      3'b000:  f3_op = alu_add;
      3'b001:  f3_op = alu_sll;
      3'b010:  f3_op = alu_slt;
      3'b011:  f3_op = alu_sltu;
      3'b100:  f3_op = alu_xor;
      3'b101:  f3_op = alu_srl;
      3'b110:  f3_op = alu_or;
      default: f3_op = alu_and;
    endcase
  end

  always_comb begin
    instr_class = cls_invalid;
    alu_op = alu_add;
    use_imm = 1'b1;
    funct3 = f3;
    case (opcode)
      op_lui:   instr_class = cls_lui;
      op_auipc: instr_class = cls_auipc;
      op_jal: begin
        instr_class = cls_jump;
        use_imm = 1'b0;
        funct3 = 3'b000;
      end
      op_jalr: begin
        if (f3 == 3'b000) instr_class = cls_jump;
        // undefined branch code, so the alu reports not taken
        funct3 = 3'b010;
      end
      op_branch: begin
        use_imm = 1'b0;
        if (f3[2:1] != 2'b01) instr_class = cls_branch;
      end
      op_load:  if (f3 == 3'b010) instr_class = cls_load;
      op_store: if (f3 == 3'b010) instr_class = cls_store;
      op_imm: begin
        alu_op = f3_op;
        if (f3 == 3'b001) begin
          if (f7 == 7'b0000000) instr_class = cls_alu;
        end else if (f3 == 3'b101) begin
          if (f7 == 7'b0000000) instr_class = cls_alu;
          if (f7 == 7'b0100000) begin
            instr_class = cls_alu;
            alu_op = alu_sra;
          end
        end else begin
          instr_class = cls_alu;
        end
      end
      op_reg: begin
        use_imm = 1'b0;
        alu_op = f3_op;
        if (f7 == 7'b0000000) begin
          instr_class = cls_alu;
        end else if (f7 == 7'b0100000 && f3 == 3'b000) begin
          instr_class = cls_alu;
          alu_op = alu_sub;
        end else if (f7 == 7'b0100000 && f3 == 3'b101) begin
          instr_class = cls_alu;
          alu_op = alu_sra;
        end
      end
      default: instr_class = cls_invalid;
    endcase
  end

  always_comb begin
    case (instr_class)
      cls_lui, cls_auipc: imm = {instr.u.imm_31_12, 12'b0};
      cls_jump: begin
        if (is_jal) begin
          imm = {{12{instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
                 instr.j.imm_10_1, 1'b0};
        end else begin
          imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
        end
      end
      cls_branch: imm = {{20{instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
                         instr.b.imm_4_1, 1'b0};
      cls_store: imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      cls_load, cls_alu: imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
      default: imm = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/rv_regfile.sv
`default_nettype none
`timescale 1ns/10ps

module rv_regfile (
  input  logic                          clk,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic                          wr_en,
  input  logic [rv_pkg::xlen-1:0]       wr_data,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [0:2**reg_addr_w-1];

  // entry 0 is never written, reads of x0 are forced to zero
  always_ff @(posedge clk) begin
    if (wr_en && rd != '0) begin
      regs[rd] <= wr_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- rtl/rv_alu.sv
`default_nettype none
`timescale 1ns/10ps

module rv_alu (
  input  logic [rv_pkg::xlen-1:0]     a,
  input  logic [rv_pkg::xlen-1:0]     b,
  input  logic [rv_pkg::alu_op_w-1:0] alu_op,
  input  logic [2:0]                  funct3,
  output logic [rv_pkg::xlen-1:0]     result,
  output logic                        taken
);
  import rv_pkg::*;

  logic [$clog2(xlen)-1:0] shamt;
  logic                    equal;
  logic                    less;
  logic                    less_u;

  assign shamt = b[$clog2(xlen)-1:0];
  assign equal = a == b;
  assign less = $signed(a) < $signed(b);
  assign less_u = a < b;

  always_comb begin
    case (alu_op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, less};
      alu_sltu: result = {{(xlen-1){1'b0}}, less_u};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = $signed(a) >>> shamt;
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = '0;
    endcase
  end

  // codes 010 and 011 are not branches and are never taken
  always_comb begin
    case (funct3)
      3'b000:  taken = equal;
      3'b001:  taken = !equal;
      3'b100:  taken = less;
      3'b101:  taken = !less;
      3'b110:  taken = less_u;
      3'b111:  taken = !less_u;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/rv_control.sv
`default_nettype none
`timescale 1ns/10ps

module rv_control (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          mem_ready,
  input  logic [rv_pkg::xlen-1:0]       mem_rdata,
  input  logic [2:0]                    instr_class,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic [rv_pkg::xlen-1:0]       imm,
  input  logic [rv_pkg::xlen-1:0]       rs1_data,
  input  logic [rv_pkg::xlen-1:0]       rs2_data,
  input  logic [rv_pkg::xlen-1:0]       alu_result,
  input  logic                          taken,
  output logic                          mem_valid,
  output logic                          mem_instr,
  output logic [rv_pkg::xlen-1:0]       mem_addr,
  output logic [rv_pkg::xlen-1:0]       mem_wdata,
  output logic [rv_pkg::xlen/8-1:0]     mem_wstrb,
  output logic                          trap,
  output rv_pkg::instr_t                instr,
  output logic                          wr_en,
  output logic [rv_pkg::xlen-1:0]       wr_data
);
  import rv_pkg::*;

  logic [2:0]      state;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_rel;
  logic [xlen-1:0] ls_addr;
  logic [xlen-1:0] target;
  logic [xlen-1:0] target_next;
  logic            is_store;
  logic            exec_fault;

  assign pc_plus4 = pc + xlen'(4);
  assign pc_rel = pc + imm;
  assign ls_addr = rs1_data + imm;
  assign is_store = instr_class == cls_store;
  assign exec_fault = instr_class == cls_invalid ||
                      ((instr_class == cls_load || is_store) && ls_addr[1:0] != 2'b00);

  // jal is always taken, jalr never, so a not-taken jump goes to rs1 + imm
  always_comb begin
    if (taken) begin
      target_next = pc_rel;
    end else if (instr_class == cls_branch) begin
      target_next = pc_plus4;
    end else begin
      target_next = {alu_result[xlen-1:1], 1'b0};
    end
  end

  assign wr_en = state == st_reg_write && rd != '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_addr <= reset_pc;
      mem_wstrb <= '0;
      trap <= 1'b0;
      next_pc <= reset_pc;
    end else begin
      case (state)
        st_fetch: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_addr <= next_pc;
          mem_wstrb <= '0;
          state <= st_wait_fetch;
        end
        st_wait_fetch: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            state <= st_execute;
          end
        end
        st_execute: begin
          if (exec_fault) begin
            trap <= 1'b1;
            state <= st_trap;
          end else begin
            case (instr_class)
              cls_load, cls_store: begin
                mem_valid <= 1'b1;
                mem_instr <= 1'b0;
                mem_addr <= ls_addr;
                mem_wstrb <= {(xlen/8){is_store}};
                state <= is_store ? st_wait_store : st_wait_load;
              end
              cls_jump, cls_branch: state <= st_check_pc;
              default: begin
                next_pc <= pc_plus4;
                state <= st_reg_write;
              end
            endcase
          end
        end
        st_wait_load: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            next_pc <= pc_plus4;
            state <= st_reg_write;
          end
        end
        st_wait_store: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            next_pc <= pc_plus4;
            state <= st_fetch;
          end
        end
        st_check_pc: begin
          if (target[1:0] != 2'b00) begin
            trap <= 1'b1;
            state <= st_trap;
          end else begin
            next_pc <= target;
            state <= (instr_class == cls_branch) ? st_fetch : st_reg_write;
          end
        end
        st_reg_write: state <= st_fetch;
        default: trap <= 1'b1;
      endcase
    end
  end

  // instruction, operands and write-back value
  always_ff @(posedge clk) begin
    case (state)
      st_wait_fetch: begin
        if (mem_ready) begin
          pc <= mem_addr;
          instr <= mem_rdata;
        end
      end
      st_execute: begin
        target <= target_next;
        mem_wdata <= rs2_data;
        case (instr_class)
          cls_lui:   wr_data <= imm;
          cls_auipc: wr_data <= pc_rel;
          cls_jump:  wr_data <= pc_plus4;
          default:   wr_data <= alu_result;
        endcase
      end
      st_wait_load: begin
        if (mem_ready) wr_data <= mem_rdata;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
`default_nettype none
`timescale 1ns/10ps

module rv_core (
  input  logic                      clk,
  input  logic                      reset,
  output logic                      mem_valid,
  output logic                      mem_instr,
  input  logic                      mem_ready,
  output logic [rv_pkg::xlen-1:0]   mem_addr,
  output logic [rv_pkg::xlen-1:0]   mem_wdata,
  output logic [rv_pkg::xlen/8-1:0] mem_wstrb,
  input  logic [rv_pkg::xlen-1:0]   mem_rdata,
  output logic                      trap
);
  import rv_pkg::*;

  instr_t                instr;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       imm;
  logic [2:0]            instr_class;
  logic [alu_op_w-1:0]   alu_op;
  logic                  use_imm;
  logic [2:0]            funct3;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       alu_b;
  logic [xlen-1:0]       alu_result;
  logic                  taken;
  logic                  wr_en;
  logic [xlen-1:0]       wr_data;

  // branches clear use_imm so the compare sees rs2
  assign alu_b = use_imm ? imm : rs2_data;

  rv_decode u_decode (
    .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .instr_class(instr_class), .alu_op(alu_op), .use_imm(use_imm), .funct3(funct3)
  );

  rv_regfile u_regfile (
    .clk(clk), .rs1(rs1), .rs2(rs2), .rd(rd), .wr_en(wr_en), .wr_data(wr_data),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv_alu u_alu (
    .a(rs1_data), .b(alu_b), .alu_op(alu_op), .funct3(funct3),
    .result(alu_result), .taken(taken)
  );

  rv_control u_control (
    .clk(clk), .reset(reset), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
    .instr_class(instr_class), .rd(rd), .imm(imm), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .alu_result(alu_result), .taken(taken),
    .mem_valid(mem_valid), .mem_instr(mem_instr), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .trap(trap), .instr(instr),
    .wr_en(wr_en), .wr_data(wr_data)
  );

endmodule

`default_nettype wire

//--- sim/tb_mem.sv
`default_nettype none
`timescale 1ns/10ps

module tb_mem (
  input  logic        clk,
  input  logic        reset,
  input  logic        mem_valid,
  input  logic        mem_instr,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic [3:0]  mem_wstrb,
  output logic        mem_ready,
  output logic [31:0] mem_rdata,
  input  logic [1:0]  ready_delay,
  input  logic        load_en,
  input  logic [31:0] load_addr,
  input  logic [31:0] load_data,
  output logic        store_seen,
  output logic [31:0] store_addr,
  output logic [31:0] store_data
);
  localparam int depth = 256;

  logic [31:0] words [0:depth-1];
  logic        busy;
  logic [1:0]  wait_left;
  logic [7:0]  index;

  assign index = mem_addr[9:2];

  // every word gets a value that depends on its full index
  initial begin
    for (int i = 0; i < depth; i++) begin
      words[i] <= (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
    end
    mem_ready <= 1'b0;
    mem_rdata <= '0;
    busy <= 1'b0;
    wait_left <= '0;
    store_seen <= 1'b0;
    store_addr <= '0;
    store_data <= '0;
  end

  always @(posedge clk) begin
    if (load_en) begin
      words[load_addr[9:2]] <= load_data;
    end
    if (reset) begin
      mem_ready <= 1'b0;
      busy <= 1'b0;
      store_seen <= 1'b0;
    end else if (mem_ready) begin
      mem_ready <= 1'b0;
      busy <= 1'b0;
    end else if (mem_valid) begin
      // the delay is latched when a request first shows up
      if (!busy && ready_delay != 2'd0) begin
        busy <= 1'b1;
        wait_left <= ready_delay - 2'd1;
      end else if (busy && wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else begin
        mem_ready <= 1'b1;
        busy <= 1'b1;
        mem_rdata <= words[index];
        // only data accesses write, fetches are reads
        if (!mem_instr && mem_wstrb == 4'hf) begin
          words[index] <= mem_wdata;
          store_seen <= 1'b1;
          store_addr <= mem_addr;
          store_data <= mem_wdata;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/core_sva.sv
`default_nettype none
`timescale 1ns/10ps

module core_sva (
  input logic                      clk,
  input logic                      reset,
  input logic                      mem_valid,
  input logic                      mem_instr,
  input logic                      mem_ready,
  input logic [rv_pkg::xlen-1:0]   mem_addr,
  input logic [rv_pkg::xlen-1:0]   mem_wdata,
  input logic [rv_pkg::xlen/8-1:0] mem_wstrb,
  input logic                      trap
);

  // a request is held until the memory accepts it
  assert property (@(posedge clk) disable iff (reset) mem_valid && !mem_ready |=> mem_valid)
    else $error("mem_valid fell before mem_ready");

  assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=> $stable(mem_addr) && $stable(mem_wdata) &&
                                $stable(mem_wstrb) && $stable(mem_instr))
    else $error("memory request changed while waiting for mem_ready");

  assert property (@(posedge clk) disable iff (reset) mem_valid |-> mem_addr[1:0] == 2'b00)
    else $error("mem_addr is not word aligned");

  // instruction fetches are always reads
  assert property (@(posedge clk) disable iff (reset)
    mem_valid && mem_instr |-> mem_wstrb == '0)
    else $error("instruction fetch with a nonzero write strobe");

  assert property (@(posedge clk) reset |=> !mem_valid)
    else $error("mem_valid high right after reset");

  // no requests once trapped, and trap only clears on reset
  assert property (@(posedge clk) disable iff (reset) trap |-> !mem_valid)
    else $error("mem_valid high while trap is set");

  assert property (@(posedge clk) disable iff (reset) trap |=> trap)
    else $error("trap fell without reset");

endmodule

`default_nettype wire

//--- sim/tb_core.sv
`default_nettype none
`timescale 1ns/10ps

module tb_core;
  import rv_pkg::*;

  localparam int n_rows = 35;
  localparam int trap_timeout = 400;
  localparam logic [31:0] test_pc = 32'd20;
  localparam logic [31:0] data_addr = 32'h80;
  localparam logic [31:0] store_target = 32'h100;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        mem_valid;
  logic        mem_instr;
  logic        mem_ready;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_rdata;
  logic        trap;
  logic [1:0]  ready_delay = 2'd0;
  logic [31:0] delay_state = 32'd46210;
  logic        load_en = 1'b0;
  logic [31:0] load_addr = '0;
  logic [31:0] load_data = '0;
  logic        store_seen;
  logic [31:0] store_addr;
  logic [31:0] store_data;
  int          fetch_count = 0;

  // test table, one row per instruction under test
  logic [6:0]  t_op [0:n_rows-1];
  logic [2:0]  t_f3 [0:n_rows-1];
  logic [6:0]  t_f7 [0:n_rows-1];
  logic [31:0] t_imm [0:n_rows-1];
  logic        t_same [0:n_rows-1];
  logic [31:0] t_a [0:n_rows-1];
  logic [31:0] t_b [0:n_rows-1];
  logic [31:0] t_load [0:n_rows-1];
  logic [31:0] t_expect [0:n_rows-1];
  logic        t_no_store [0:n_rows-1];
  int          row_count = 0;
  int          current_row = 0;
  logic [31:0] rng_state = 32'd46210;
  logic [31:0] prog [0:8];

  rv_core uut (
    .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_instr(mem_instr),
    .mem_ready(mem_ready), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb), .mem_rdata(mem_rdata), .trap(trap)
  );

  tb_mem mem_model (
    .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_instr(mem_instr),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
    .mem_ready(mem_ready), .mem_rdata(mem_rdata), .ready_delay(ready_delay),
    .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
    .store_seen(store_seen), .store_addr(store_addr), .store_data(store_data)
  );

  bind rv_control core_sva u_sva (
    .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_instr(mem_instr),
    .mem_ready(mem_ready), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb), .trap(trap)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // new ready delay of 0 to 3 cycles every clock
  always @(posedge clk) begin
    delay_state <= xorshift(delay_state);
    ready_delay <= delay_state[1:0];
  end

  // instruction fetches completed since the last reset
  always @(posedge clk) begin
    if (reset) begin
      fetch_count <= 0;
    end else if (mem_valid && mem_ready && mem_instr) begin
      fetch_count <= fetch_count + 1;
    end
  end

  task automatic draw_random(output logic [31:0] value);
    rng_state = xorshift(rng_state);
    value = rng_state;
  endtask

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      stop_with_failure($sformatf("mismatch at %0t ns: %s (row %0d) got 0x%08h expected 0x%08h",
                                  $time, name, current_row, got, want));
    end
  endtask

  function automatic logic [31:0] encode(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [6:0] f7, input logic [31:0] imm,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    case (op)
      op_reg:           return {f7, rs2, rs1, f3, rd, op};
      op_branch:        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
      op_store:         return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
      op_lui, op_auipc: return {imm[31:12], rd, op};
      op_jal:           return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
      default:          return {imm[11:0], rs1, f3, rd, op};
    endcase
  endfunction

  function automatic logic [31:0] alu_reference(input logic [2:0] f3, input logic alt,
                                                input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'd0, $signed(a) < $signed(b)};
      3'd3: r = {31'd0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_reference(input logic [2:0] f3, input logic [31:0] a,
                                            input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // top bit set means no store may reach memory
  function automatic logic [32:0] expected_result(input int idx);
    logic [31:0] tgt;
    case (t_op[idx])
      op_reg:    return {1'b0, alu_reference(t_f3[idx], t_f7[idx][5], t_a[idx], t_b[idx])};
      op_imm:    return {1'b0, alu_reference(t_f3[idx], t_f3[idx] == 3'd5 && t_f7[idx][5],
                                             t_a[idx], t_imm[idx])};
      op_branch: return {1'b0, 31'd0, !branch_reference(t_f3[idx], t_a[idx], t_b[idx])};
      op_lui:    return {1'b0, t_imm[idx]};
      op_auipc:  return {1'b0, test_pc + t_imm[idx]};
      op_jal:    return {1'b0, test_pc + 32'd4};
      op_jalr: begin
        tgt = t_imm[idx] & ~32'd1;
        return {tgt[1:0] != 2'b00, test_pc + 32'd4};
      end
      op_load:   return {t_imm[idx][1:0] != 2'b00, t_load[idx]};
      default:   return {t_imm[idx][1:0] != 2'b00, 32'd0};
    endcase
  endfunction

  // fetches up to the trap, following the program layout of run_row
  function automatic int expected_fetches(input int idx);
    if (t_no_store[idx]) return 6;
    if (t_op[idx] == op_branch && t_expect[idx][0]) return 9;
    return 8;
  endfunction

  task automatic add_row(input logic [6:0] op, input logic [2:0] f3, input logic [6:0] f7,
                         input logic [31:0] imm, input logic same);
    t_op[row_count] = op;
    t_f3[row_count] = f3;
    t_f7[row_count] = f7;
    t_imm[row_count] = imm;
    t_same[row_count] = same;
    row_count = row_count + 1;
  endtask

  task automatic fill_table();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ld;
    logic [31:0] r;
    for (int i = 0; i < n_rows; i++) begin
      draw_random(a);
      draw_random(b);
      draw_random(ld);
      draw_random(r);
      t_a[i] = a;
      t_b[i] = t_same[i] ? a : b;
      t_load[i] = ld;
      if (t_op[i] == op_imm) begin
        if (t_f3[i] == 3'd1 || t_f3[i] == 3'd5) t_imm[i] = {20'd0, t_f7[i], r[4:0]};
        else t_imm[i] = {{20{r[11]}}, r[11:0]};
      end else if (t_op[i] == op_lui || t_op[i] == op_auipc) begin
        t_imm[i] = {r[31:12], 12'd0};
      end
      {t_no_store[i], t_expect[i]} = expected_result(i);
    end
  endtask

  task automatic run_row(input int idx);
    logic [31:0] lo_a;
    logic [31:0] lo_b;
    logic [4:0]  rs1_t;
    logic [4:0]  rs2_t;
    int          n;
    current_row = idx;
    lo_a = {{20{t_a[idx][11]}}, t_a[idx][11:0]};
    lo_b = {{20{t_b[idx][11]}}, t_b[idx][11:0]};
    rs1_t = (t_op[idx] == op_jalr || t_op[idx] == op_load || t_op[idx] == op_store) ?
            5'd0 : 5'd1;
    rs2_t = (t_op[idx] == op_store) ? 5'd1 : 5'd2;
    prog[0] = encode(op_lui, 3'd0, 7'd0, t_a[idx] - lo_a, 5'd1, 5'd0, 5'd0);
    prog[1] = encode(op_imm, 3'd0, 7'd0, lo_a, 5'd1, 5'd1, 5'd0);
    prog[2] = encode(op_lui, 3'd0, 7'd0, t_b[idx] - lo_b, 5'd2, 5'd0, 5'd0);
    prog[3] = encode(op_imm, 3'd0, 7'd0, lo_b, 5'd2, 5'd2, 5'd0);
    prog[4] = encode(op_imm, 3'd0, 7'd0, 32'd0, 5'd3, 5'd0, 5'd0);
    prog[5] = encode(t_op[idx], t_f3[idx], t_f7[idx], t_imm[idx], 5'd3, rs1_t, rs2_t);
    prog[8] = 32'd0;
    if (t_op[idx] == op_branch || t_op[idx] == op_jal || t_op[idx] == op_jalr) begin
      // skipped when the branch or jump is taken
      if (t_op[idx] == op_branch) begin
        prog[6] = encode(op_imm, 3'd0, 7'd0, 32'd1, 5'd3, 5'd0, 5'd0);
      end else begin
        // a jump that falls through runs into this zero word and traps
        prog[6] = 32'd0;
      end
      prog[7] = encode(op_store, 3'd2, 7'd0, store_target, 5'd0, 5'd0, 5'd3);
    end else begin
      prog[6] = encode(op_store, 3'd2, 7'd0, store_target, 5'd0, 5'd0, 5'd3);
      prog[7] = 32'd0;
    end
    // ten reset cycles, one memory word written in each
    for (n = 0; n < 10; n++) begin
      @(posedge clk);
      reset <= 1'b1;
      load_en <= 1'b1;
      if (n < 9) begin
        load_addr <= 32'(n * 4);
        load_data <= prog[n];
      end else begin
        load_addr <= data_addr;
        load_data <= t_load[idx];
      end
    end
    @(posedge clk);
    reset <= 1'b0;
    load_en <= 1'b0;
    @(negedge clk);
    check_value("trap", 32'(trap), 32'd0);
    for (n = 0; n < trap_timeout && trap !== 1'b1; n++) begin
      @(negedge clk);
    end
    assert (trap === 1'b1) else begin
      stop_with_failure($sformatf("timeout: trap not raised within %0d cycles in row %0d",
                                  trap_timeout, idx));
    end
    if (t_no_store[idx]) begin
      check_value("store_seen", 32'(store_seen), 32'd0);
    end else begin
      check_value("store_seen", 32'(store_seen), 32'd1);
      check_value("store_addr", store_addr, store_target);
      check_value("store_data", store_data, t_expect[idx]);
    end
    check_value("fetch_count", 32'(fetch_count), 32'(expected_fetches(idx)));
    repeat (5) @(negedge clk);
    check_value("trap", 32'(trap), 32'd1);
  endtask

  initial begin
    add_row(op_reg, 3'd0, 7'h00, 32'd0, 1'b0);
    add_row(op_reg, 3'd0, 7'h20, 32'd0, 1'b0);
    add_row(op_reg, 3'd1, 7'h00, 32'd0, 1'b0);
    add_row(op_reg, 3'd2, 7'h00, 32'd0, 1'b0);
    add_row(op_reg, 3'd3, 7'h00, 32'd0, 1'b0);
    add_row(op_reg, 3'd4, 7'h00, 32'd0, 1'b0);
    add_row(op_reg, 3'd5, 7'h00, 32'd0, 1'b0);
    add_row(op_reg, 3'd5, 7'h20, 32'd0, 1'b0);
    add_row(op_reg, 3'd6, 7'h00, 32'd0, 1'b0);
    add_row(op_reg, 3'd7, 7'h00, 32'd0, 1'b0);
    add_row(op_imm, 3'd0, 7'h00, 32'd0, 1'b0);
    add_row(op_imm, 3'd1, 7'h00, 32'd0, 1'b0);
    add_row(op_imm, 3'd2, 7'h00, 32'd0, 1'b0);
    add_row(op_imm, 3'd3, 7'h00, 32'd0, 1'b0);
    add_row(op_imm, 3'd4, 7'h00, 32'd0, 1'b0);
    add_row(op_imm, 3'd5, 7'h00, 32'd0, 1'b0);
    add_row(op_imm, 3'd5, 7'h20, 32'd0, 1'b0);
    add_row(op_imm, 3'd6, 7'h00, 32'd0, 1'b0);
    add_row(op_imm, 3'd7, 7'h00, 32'd0, 1'b0);
    add_row(op_branch, 3'd0, 7'h00, 32'd8, 1'b0);
    add_row(op_branch, 3'd0, 7'h00, 32'd8, 1'b1);
    add_row(op_branch, 3'd1, 7'h00, 32'd8, 1'b0);
    add_row(op_branch, 3'd1, 7'h00, 32'd8, 1'b1);
    add_row(op_branch, 3'd4, 7'h00, 32'd8, 1'b0);
    add_row(op_branch, 3'd5, 7'h00, 32'd8, 1'b0);
    add_row(op_branch, 3'd6, 7'h00, 32'd8, 1'b0);
    add_row(op_branch, 3'd7, 7'h00, 32'd8, 1'b0);
    add_row(op_lui, 3'd0, 7'h00, 32'd0, 1'b0);
    add_row(op_auipc, 3'd0, 7'h00, 32'd0, 1'b0);
    add_row(op_jal, 3'd0, 7'h00, 32'd8, 1'b0);
    add_row(op_jalr, 3'd0, 7'h00, 32'd28, 1'b0);
    add_row(op_jalr, 3'd0, 7'h00, 32'd26, 1'b0);
    add_row(op_load, 3'd2, 7'h00, data_addr, 1'b0);
    add_row(op_load, 3'd2, 7'h00, data_addr + 32'd2, 1'b0);
    add_row(op_store, 3'd2, 7'h00, store_target + 32'd2, 1'b0);
    fill_table();
    for (int i = 0; i < n_rows; i++) begin
      run_row(i);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
rtl/rv_pkg.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_control.sv
rtl/rv_core.sv
sim/tb_mem.sv
sim/core_sva.sv
sim/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_core -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
